// File: common/archPkg.sv
//////////////////////////////////////////////////////////////////////
// architecture constants for the 16-bit instruction decoder
// register ids, micro-op codes, condition codes and sub-commands
//////////////////////////////////////////////////////////////////////
`default_nettype none

package archPkg;

	localparam int instrWidth = 16;
	localparam int regIdWidth = 6;
	localparam int immWidth = 33;

	typedef logic [regIdWidth-1:0] regId_t;
	typedef logic [5:0] ucmd_t;
	typedef logic [1:0] ccty_t;

	// special registers, GPRs sit at 0x00..0x1F
	localparam regId_t grDlr = 6'h20;
	localparam regId_t grDhr = 6'h21;
	localparam regId_t grPc = 6'h22;
	localparam regId_t grGbr = 6'h23;
	localparam regId_t grLr = 6'h24;
	localparam regId_t grSp = 6'h2F;
	localparam regId_t grImm = 6'h3E;
	localparam regId_t grZzr = 6'h3F;

	localparam ucmd_t ucmdNop = 6'h00;
	localparam ucmd_t ucmdInvOp = 6'h01;
	localparam ucmd_t ucmdMovRm = 6'h02;
	localparam ucmd_t ucmdMovMr = 6'h03;
	localparam ucmd_t ucmdAlu3 = 6'h04;
	localparam ucmd_t ucmdAluCmp = 6'h05;
	localparam ucmd_t ucmdConvRr = 6'h06;
	localparam ucmd_t ucmdBra = 6'h08;
	localparam ucmd_t ucmdBsr = 6'h09;
	localparam ucmd_t ucmdJmp = 6'h0A;
	localparam ucmd_t ucmdMovIr = 6'h0C;
	localparam ucmd_t ucmdOpIxt = 6'h0E;

	localparam ccty_t ccAlways = 2'b00;
	localparam ccty_t ccIfTrue = 2'b10;
	localparam ccty_t ccIfFalse = 2'b11;

	// sub-commands, numbered per major op
	localparam logic [5:0] ucixAdd = 6'h00;
	localparam logic [5:0] ucixSub = 6'h01;
	localparam logic [5:0] ucixAdc = 6'h02;
	localparam logic [5:0] ucixSbb = 6'h03;
	localparam logic [5:0] ucixTst = 6'h04;
	localparam logic [5:0] ucixAnd = 6'h05;
	localparam logic [5:0] ucixOr = 6'h06;
	localparam logic [5:0] ucixXor = 6'h07;
	localparam logic [5:0] ucixCmpEq = 6'h08;
	localparam logic [5:0] ucixCmpHi = 6'h09;
	localparam logic [5:0] ucixCmpGt = 6'h0A;
	localparam logic [5:0] ucixCmpGe = 6'h0B;
	localparam logic [5:0] ucixConvMov = 6'h00;
	localparam logic [5:0] ucixLdiX = 6'h00;
	localparam logic [5:0] ucixLdiSh8 = 6'h01;
	localparam logic [5:0] ucixLdiSh16 = 6'h02;
	localparam logic [5:0] ucixSleep = 6'h01;
	localparam logic [5:0] ucixBreak = 6'h02;
	localparam logic [5:0] ucixClrt = 6'h04;
	localparam logic [5:0] ucixSett = 6'h05;
	localparam logic [5:0] ucixClrs = 6'h06;
	localparam logic [5:0] ucixSets = 6'h07;
	localparam logic [5:0] ucixNott = 6'h08;
	localparam logic [5:0] ucixNots = 6'h09;
	localparam logic [5:0] ucixRte = 6'h0C;

endpackage

`default_nettype wire

// File: common/decodePkg.sv
//////////////////////////////////////////////////////////////////////
// decoder-internal codes shared by the classify and operand stages
// instruction form, index type and access size
//////////////////////////////////////////////////////////////////////
`default_nettype none

package decodePkg;

	typedef logic [4:0] form_t;
	typedef logic [3:0] ity_t;
	typedef logic [2:0] bty_t;

	localparam form_t fmInv = 5'h00;
	localparam form_t fmZ = 5'h01;
	localparam form_t fmRegReg = 5'h02;
	localparam form_t fmImm8Reg = 5'h03;
	localparam form_t fmImm8Z = 5'h04;
	localparam form_t fmImm8N = 5'h05;
	localparam form_t fmRegStReg = 5'h06;
	localparam form_t fmLdRegReg = 5'h07;
	localparam form_t fmRegStDrReg = 5'h08;
	localparam form_t fmLdDrRegReg = 5'h09;
	localparam form_t fmImm4ZReg = 5'h0A;
	localparam form_t fmImm4NReg = 5'h0B;
	localparam form_t fmPcDisp8 = 5'h0C;
	localparam form_t fmImm12Z = 5'h0D;
	localparam form_t fmImm12N = 5'h0E;

	// register selection inside the reg-reg forms
	localparam ity_t itySb = 4'h0;
	localparam ity_t itySw = 4'h1;
	localparam ity_t itySl = 4'h2;
	localparam ity_t itySq = 4'h3;
	localparam ity_t ityNb = 4'h8;

	// bit 2 would mark unsigned
	localparam bty_t btySb = 3'b000;
	localparam bty_t btySw = 3'b001;
	localparam bty_t btySl = 3'b010;
	localparam bty_t btySq = 3'b011;

endpackage

`default_nettype wire

// File: hw/decoder/regFieldExpand.sv
//////////////////////////////////////////////////////////////////////
// register field expansion
// maps the O, N and M nibbles to default and extended register ids
// and flags N/M fields that name R0 or R1
//////////////////////////////////////////////////////////////////////
`default_nettype none

module regFieldExpand (
	input wire logic [archPkg::instrWidth-1:0] word,
	output archPkg::regId_t nDfl,
	output archPkg::regId_t mDfl,
	output archPkg::regId_t oDfl,
	output archPkg::regId_t nEr,
	output archPkg::regId_t mEr,
	output archPkg::regId_t oEr,
	output logic nIsZero,
	output logic nIsOne,
	output logic mIsZero,
	output logic mIsOne
);

	// R0, R1 and R15 land in the special register space
	function automatic archPkg::regId_t expand(input logic [3:0] nib, input logic ext);
		logic special;
		special = (nib[3:1] == 3'b000) || (nib == 4'hF);
		return {special, ext, nib};
	endfunction

	assign oDfl = expand(word[11:8], 1'b0);
	assign nDfl = expand(word[7:4], 1'b0);
	assign mDfl = expand(word[3:0], 1'b0);
	assign oEr = expand(word[11:8], 1'b1);
	assign nEr = expand(word[7:4], 1'b1);
	assign mEr = expand(word[3:0], 1'b1);

	assign nIsZero = (word[7:4] == 4'h0);
	assign nIsOne = (word[7:4] == 4'h1);
	assign mIsZero = (word[3:0] == 4'h0);
	assign mIsOne = (word[3:0] == 4'h1);

endmodule

`default_nettype wire

// File: hw/decoder/opcodeClassify.sv
//////////////////////////////////////////////////////////////////////
// opcode classifier
// pattern match over the 16-bit opcode space, gives the major op,
// instruction form, access size, index type, condition and sub-command
//////////////////////////////////////////////////////////////////////
`default_nettype none

module opcodeClassify (
	input wire logic [archPkg::instrWidth-1:0] word,
	output archPkg::ucmd_t major,
	output decodePkg::form_t form,
	output decodePkg::bty_t bty,
	output decodePkg::ity_t ity,
	output archPkg::ccty_t ccty,
	output logic [5:0] subCmd
);

	always_comb begin
		major = archPkg::ucmdInvOp;
		form = decodePkg::fmInv;
		bty = decodePkg::btySb;
		ity = decodePkg::itySb;
		ccty = archPkg::ccAlways;
		subCmd = 6'h00;

		casez (word[15:8])
			8'b0000_????: begin
				// bit 11 picks load, bit 10 the displacement form
				major = word[11] ? archPkg::ucmdMovMr : archPkg::ucmdMovRm;
				bty = {1'b0, word[9:8]};
				case (word[11:10])
					2'b00: form = decodePkg::fmRegStReg;
					2'b01: form = decodePkg::fmRegStDrReg;
					2'b10: form = decodePkg::fmLdRegReg;
					default: form = decodePkg::fmLdDrRegReg;
				endcase
				if (word == 16'h0000) begin
					major = archPkg::ucmdNop;
					form = decodePkg::fmZ;
				end
			end
			8'h10, 8'h11, 8'h12, 8'h13, 8'h15, 8'h16, 8'h17: begin
				major = archPkg::ucmdAlu3;
				form = decodePkg::fmRegReg;
				ity = decodePkg::ityNb;
				case (word[11:8])
					4'h0: subCmd = archPkg::ucixAdd;
					4'h1: subCmd = archPkg::ucixSub;
					4'h2: subCmd = archPkg::ucixAdc;
					4'h3: subCmd = archPkg::ucixSbb;
					4'h5: subCmd = archPkg::ucixAnd;
					4'h6: subCmd = archPkg::ucixOr;
					default: subCmd = archPkg::ucixXor;
				endcase
			end
			8'h14: begin
				major = archPkg::ucmdAluCmp;
				form = decodePkg::fmRegReg;
				subCmd = archPkg::ucixTst;
			end
			8'b0001_10??: begin
				// MOV, size selects the basic or extended bank per field
				major = archPkg::ucmdConvRr;
				form = decodePkg::fmRegReg;
				ity = {2'b00, word[9:8]};
				subCmd = archPkg::ucixConvMov;
			end
			8'h1C, 8'h1D, 8'h1E: begin
				major = archPkg::ucmdAluCmp;
				form = decodePkg::fmRegReg;
				case (word[9:8])
					2'b00: subCmd = archPkg::ucixCmpEq;
					2'b01: subCmd = archPkg::ucixCmpHi;
					default: subCmd = archPkg::ucixCmpGt;
				endcase
			end
			8'b0010_00??: begin
				major = (word[9:8] == 2'b01) ? archPkg::ucmdBsr : archPkg::ucmdBra;
				form = decodePkg::fmPcDisp8;
				bty = decodePkg::btySw;
				if (word[9:8] == 2'b10)
					ccty = archPkg::ccIfTrue;
				else if (word[9:8] == 2'b11)
					ccty = archPkg::ccIfFalse;
			end
			8'h24, 8'h25, 8'h26: begin
				major = archPkg::ucmdMovIr;
				form = (word[9:8] == 2'b01) ? decodePkg::fmImm8N : decodePkg::fmImm8Z;
				subCmd = word[9] ? archPkg::ucixLdiSh8 : archPkg::ucixLdiX;
			end
			8'b0010_11??: begin
				major = archPkg::ucmdAluCmp;
				form = (word[9:8] == 2'b01) ? decodePkg::fmImm4NReg : decodePkg::fmImm4ZReg;
				case (word[9:8])
					2'b10: subCmd = archPkg::ucixCmpGt;
					2'b11: subCmd = archPkg::ucixCmpGe;
					default: subCmd = archPkg::ucixCmpEq;
				endcase
			end
			8'h30: begin
				major = archPkg::ucmdOpIxt;
				form = decodePkg::fmZ;
				case (word[7:0])
					8'h00: major = archPkg::ucmdNop;
					8'h10: major = archPkg::ucmdJmp;
					8'h20: subCmd = archPkg::ucixSleep;
					8'h30: subCmd = archPkg::ucixBreak;
					8'h40: subCmd = archPkg::ucixClrt;
					8'h50: subCmd = archPkg::ucixSett;
					8'h60: subCmd = archPkg::ucixClrs;
					8'h70: subCmd = archPkg::ucixSets;
					8'h80: subCmd = archPkg::ucixNott;
					8'h90: subCmd = archPkg::ucixNots;
					8'hA0, 8'hB0: begin
						major = archPkg::ucmdMovIr;
						subCmd = archPkg::ucixLdiSh16;
					end
					8'hC0: subCmd = archPkg::ucixRte;
					default: begin
						major = archPkg::ucmdInvOp;
						form = decodePkg::fmInv;
					end
				endcase
			end
			8'b101?_????: begin
				major = archPkg::ucmdMovIr;
				form = word[12] ? decodePkg::fmImm12N : decodePkg::fmImm12Z;
				subCmd = archPkg::ucixLdiX;
			end
			8'b1100_????: begin
				major = archPkg::ucmdAlu3;
				form = decodePkg::fmImm8Reg;
				subCmd = archPkg::ucixAdd;
			end
			8'b1101_????: begin
				major = archPkg::ucmdMovIr;
				form = decodePkg::fmImm8Reg;
				subCmd = archPkg::ucixLdiX;
			end
			default: begin
				major = archPkg::ucmdInvOp;
				form = decodePkg::fmInv;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/decoder/operandForm.sv
//////////////////////////////////////////////////////////////////////
// operand former
// per instruction form, routes the register ids, builds the 33-bit
// immediate and assembles the micro-op extension word
//////////////////////////////////////////////////////////////////////
`default_nettype none

module operandForm (
	input wire logic [archPkg::instrWidth-1:0] word,
	input wire decodePkg::form_t form,
	input wire decodePkg::ity_t ity,
	input wire decodePkg::bty_t bty,
	input wire archPkg::ccty_t ccty,
	input wire logic [5:0] subCmd,
	input wire archPkg::regId_t nDfl,
	input wire archPkg::regId_t mDfl,
	input wire archPkg::regId_t oDfl,
	input wire archPkg::regId_t nEr,
	input wire archPkg::regId_t mEr,
	input wire archPkg::regId_t oEr,
	input wire logic nIsZero,
	input wire logic nIsOne,
	input wire logic mIsZero,
	input wire logic mIsOne,
	output archPkg::regId_t regN,
	output archPkg::regId_t regM,
	output archPkg::regId_t regO,
	output logic [archPkg::immWidth-1:0] imm,
	output logic [7:0] uIxt
);

	localparam int immW = archPkg::immWidth;

	// R0 base means PC, R1 base means GBR
	function automatic archPkg::regId_t baseReg(input logic isZero, input logic isOne,
			input archPkg::regId_t dfl);
		if (isOne)
			return archPkg::grGbr;
		return isZero ? archPkg::grPc : dfl;
	endfunction

	// memory ext word, a remapped base drops the size to byte
	function automatic logic [7:0] memExt(input archPkg::ccty_t cc, input decodePkg::bty_t sz,
			input logic isLoad, input logic remap);
		return {cc, sz[1:0], isLoad, remap ? {sz[2], 2'b00} : sz};
	endfunction

	always_comb begin
		regN = archPkg::grZzr;
		regM = archPkg::grZzr;
		regO = archPkg::grZzr;
		imm = '0;
		uIxt = '0;

		case (form)
			decodePkg::fmZ: begin
				uIxt = {ccty, subCmd};
				if (word == 16'h3010)
					regM = archPkg::grLr;
				if (word == 16'h30B0)
					imm = 33'h0_0000_FFFF;
			end
			decodePkg::fmRegReg: begin
				uIxt = {ccty, subCmd};
				regO = archPkg::grDlr;
				case (ity)
					decodePkg::itySw: begin
						regN = nDfl;
						regM = mEr;
					end
					decodePkg::itySl: begin
						regN = nEr;
						regM = mDfl;
					end
					decodePkg::itySq: begin
						regN = nEr;
						regM = mEr;
					end
					decodePkg::ityNb: begin
						// two-operand ALU: Rn = Rn op Rm
						regN = nDfl;
						regM = nDfl;
						regO = mDfl;
					end
					default: begin
						regN = nDfl;
						regM = mDfl;
					end
				endcase
			end
			decodePkg::fmImm8Reg: begin
				uIxt = {ccty, subCmd};
				imm = {{(immW-8){word[7]}}, word[7:0]};
				regM = archPkg::grImm;
				regN = oDfl;
				regO = oDfl;
			end
			decodePkg::fmImm8Z, decodePkg::fmImm8N: begin
				uIxt = {ccty, subCmd};
				imm = {{(immW-8){form == decodePkg::fmImm8N}}, word[7:0]};
				regN = archPkg::grDlr;
				regM = archPkg::grImm;
			end
			decodePkg::fmImm12Z, decodePkg::fmImm12N: begin
				uIxt = {ccty, subCmd};
				imm = {{(immW-12){form == decodePkg::fmImm12N}}, word[11:0]};
				regN = archPkg::grDlr;
				regM = archPkg::grImm;
			end
			decodePkg::fmImm4ZReg, decodePkg::fmImm4NReg: begin
				uIxt = {ccty, subCmd};
				imm = {{(immW-4){form == decodePkg::fmImm4NReg}}, word[3:0]};
				regN = nDfl;
				regM = archPkg::grImm;
			end
			decodePkg::fmRegStReg: begin
				regM = nDfl;
				regN = mDfl;
				uIxt = memExt(ccty, bty, 1'b0, 1'b0);
			end
			decodePkg::fmLdRegReg: begin
				regN = nDfl;
				regM = mDfl;
				uIxt = memExt(ccty, bty, 1'b1, 1'b0);
			end
			decodePkg::fmRegStDrReg: begin
				regN = nDfl;
				regM = baseReg(mIsZero, mIsOne, mDfl);
				regO = archPkg::grDlr;
				uIxt = memExt(ccty, bty, 1'b0, mIsZero || mIsOne);
			end
			decodePkg::fmLdDrRegReg: begin
				regN = mDfl;
				regM = baseReg(nIsZero, nIsOne, nDfl);
				regO = archPkg::grDlr;
				uIxt = memExt(ccty, bty, 1'b1, nIsZero || nIsOne);
			end
			decodePkg::fmPcDisp8: begin
				regN = archPkg::grDlr;
				regM = archPkg::grPc;
				regO = archPkg::grImm;
				imm = {{(immW-8){word[7]}}, word[7:0]};
				uIxt = memExt(ccty, bty, 1'b1, 1'b0);
			end
			default: begin
				// invalid op, no registers and no immediate
				regN = archPkg::grZzr;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/instrDecoder.sv
//////////////////////////////////////////////////////////////////////
// instruction decoder top
// accepts one 16-bit word over a four-phase req/ack handshake and
// holds the decoded micro-op in its output register while acked
//////////////////////////////////////////////////////////////////////
`default_nettype none

module instrDecoder (
	input wire logic clock,
	input wire logic rst,
	input wire logic instrReq,
	input wire logic [archPkg::instrWidth-1:0] instrWord,
	output logic instrAck,
	output archPkg::regId_t regN,
	output archPkg::regId_t regM,
	output archPkg::regId_t regO,
	output logic [archPkg::immWidth-1:0] imm,
	output logic [7:0] uCmd,
	output logic [7:0] uIxt
);

	archPkg::regId_t nDfl, mDfl, oDfl, nEr, mEr, oEr;
	logic nIsZero, nIsOne, mIsZero, mIsOne;
	archPkg::ucmd_t major;
	decodePkg::form_t form;
	decodePkg::bty_t bty;
	decodePkg::ity_t ity;
	archPkg::ccty_t ccty;
	logic [5:0] subCmd;
	archPkg::regId_t decN, decM, decO;
	logic [archPkg::immWidth-1:0] decImm;
	logic [7:0] decUIxt;

	regFieldExpand fields (
		.word(instrWord),
		.nDfl(nDfl), .mDfl(mDfl), .oDfl(oDfl),
		.nEr(nEr), .mEr(mEr), .oEr(oEr),
		.nIsZero(nIsZero), .nIsOne(nIsOne), .mIsZero(mIsZero), .mIsOne(mIsOne)
	);

	opcodeClassify classify (
		.word(instrWord), .major(major), .form(form), .bty(bty),
		.ity(ity), .ccty(ccty), .subCmd(subCmd)
	);

	operandForm operands (
		.word(instrWord), .form(form), .ity(ity), .bty(bty), .ccty(ccty), .subCmd(subCmd),
		.nDfl(nDfl), .mDfl(mDfl), .oDfl(oDfl), .nEr(nEr), .mEr(mEr), .oEr(oEr),
		.nIsZero(nIsZero), .nIsOne(nIsOne), .mIsZero(mIsZero), .mIsOne(mIsOne),
		.regN(decN), .regM(decM), .regO(decO), .imm(decImm), .uIxt(decUIxt)
	);

	// load on req with ack low, drop ack once req is seen low
	always_ff @(posedge clock) begin
		if (rst) begin
			instrAck <= 1'b0;
			regN <= archPkg::grZzr;
			regM <= archPkg::grZzr;
			regO <= archPkg::grZzr;
			imm <= '0;
			uCmd <= {archPkg::ccAlways, archPkg::ucmdNop};
			uIxt <= '0;
		end else if (instrReq && !instrAck) begin
			instrAck <= 1'b1;
			regN <= decN;
			regM <= decM;
			regO <= decO;
			imm <= decImm;
			uCmd <= {ccty, major};
			uIxt <= decUIxt;
		end else if (!instrReq && instrAck) begin
			instrAck <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: dv/decoderChecker.sv
//////////////////////////////////////////////////////////////////////
// decoder result checker
// checks the instrAck timing, compares the DUT outputs with the
// expected row when instrAck rises, watches that they hold while
// acked and reports each test
//////////////////////////////////////////////////////////////////////
`default_nettype none

module decoderChecker (
	input wire logic clock,
	input wire logic rst,
	input wire logic instrReq,
	input wire logic instrAck,
	input wire archPkg::regId_t regN,
	input wire archPkg::regId_t regM,
	input wire archPkg::regId_t regO,
	input wire logic [archPkg::immWidth-1:0] imm,
	input wire logic [7:0] uCmd,
	input wire logic [7:0] uIxt,
	input wire logic [archPkg::instrWidth-1:0] expWord,
	input wire archPkg::regId_t expN,
	input wire archPkg::regId_t expM,
	input wire archPkg::regId_t expO,
	input wire logic [archPkg::immWidth-1:0] expImm,
	input wire logic [7:0] expCmd,
	input wire logic [7:0] expIxt,
	output int testCount,
	output int failCount
);
	timeunit 1ns;
	timeprecision 1ps;

	logic rstSeen = 1'b1;
	logic ackDue = 1'b0;
	logic idleDone = 1'b0;
	logic ackSeen = 1'b0;
	int rowErrors = 0;
	int tests = 0;
	int fails = 0;
	logic [66:0] current;
	logic [66:0] snapshot;

	assign current = {regN, regM, regO, imm, uCmd, uIxt};
	assign testCount = tests;
	assign failCount = fails;

	task automatic checkField(input string name, input logic [32:0] got,
			input logic [32:0] want);
		if (got !== want) begin
			$display("FAILED %0t: word %h %s is %h, expected %h",
				$time, expWord, name, got, want);
			rowErrors++;
		end
	endtask

	task automatic finishTest(input string label);
		tests++;
		if (rowErrors == 0) begin
			$display("test %0d (%s) passed", tests, label);
		end else begin
			fails++;
			$display("test %0d (%s) failed with %0d mismatches", tests, label, rowErrors);
		end
		rowErrors = 0;
	endtask

	// ack follows req one edge later, low in reset
	always @(posedge clock) begin
		rstSeen <= rst;
		ackDue <= !rst && instrReq;
	end

	always @(negedge clock) begin
		if (!rstSeen && instrAck !== ackDue) begin
			$display("FAILED %0t: instrAck is %b, expected %b one edge after instrReq",
				$time, instrAck, ackDue);
			rowErrors++;
		end
		if (!rstSeen && !idleDone) begin
			// first cycle out of reset, nothing requested yet
			idleDone = 1'b1;
			checkField("regN", 33'(regN), 33'(archPkg::grZzr));
			checkField("regM", 33'(regM), 33'(archPkg::grZzr));
			checkField("regO", 33'(regO), 33'(archPkg::grZzr));
			checkField("imm", imm, '0);
			checkField("uCmd", 33'(uCmd), 33'({archPkg::ccAlways, archPkg::ucmdNop}));
			checkField("uIxt", 33'(uIxt), '0);
			finishTest("reset idle");
		end else if (instrAck && !ackSeen) begin
			ackSeen = 1'b1;
			checkField("regN", 33'(regN), 33'(expN));
			checkField("regM", 33'(regM), 33'(expM));
			checkField("regO", 33'(regO), 33'(expO));
			checkField("imm", imm, expImm);
			checkField("uCmd", 33'(uCmd), 33'(expCmd));
			checkField("uIxt", 33'(uIxt), 33'(expIxt));
			snapshot = current;
		end else if (instrAck && ackSeen) begin
			if (current !== snapshot) begin
				$display("FAILED %0t: word %h outputs changed while instrAck was high",
					$time, expWord);
				rowErrors++;
			end
		end else if (!instrAck && ackSeen) begin
			ackSeen = 1'b0;
			finishTest($sformatf("word %h", expWord));
		end
	end

endmodule

`default_nettype wire

// File: dv/decoderTb.sv
//////////////////////////////////////////////////////////////////////
// instruction decoder testbench
// clock, reset, a table of words with expected decodes sent over the
// req/ack handshake, and a watchdog
//////////////////////////////////////////////////////////////////////
`default_nettype none

module decoderTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int numRows = 19;

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic instrReq = 1'b0;
	logic [archPkg::instrWidth-1:0] instrWord = '0;
	logic instrAck;
	archPkg::regId_t regN, regM, regO;
	logic [archPkg::immWidth-1:0] imm;
	logic [7:0] uCmd, uIxt;
	int testCount, failCount;

	logic [archPkg::instrWidth-1:0] tWord [numRows];
	archPkg::regId_t tN [numRows];
	archPkg::regId_t tM [numRows];
	archPkg::regId_t tO [numRows];
	logic [archPkg::immWidth-1:0] tImm [numRows];
	logic [7:0] tCmd [numRows];
	logic [7:0] tIxt [numRows];
	int rowFill = 0;
	int rowIdx = 0;

	always #50 clock = ~clock;

	instrDecoder UUT (
		.clock(clock), .rst(rst), .instrReq(instrReq), .instrWord(instrWord),
		.instrAck(instrAck), .regN(regN), .regM(regM), .regO(regO),
		.imm(imm), .uCmd(uCmd), .uIxt(uIxt)
	);

	decoderChecker resultCheck (
		.clock(clock), .rst(rst), .instrReq(instrReq), .instrAck(instrAck),
		.regN(regN), .regM(regM), .regO(regO), .imm(imm), .uCmd(uCmd), .uIxt(uIxt),
		.expWord(tWord[rowIdx]), .expN(tN[rowIdx]), .expM(tM[rowIdx]), .expO(tO[rowIdx]),
		.expImm(tImm[rowIdx]), .expCmd(tCmd[rowIdx]), .expIxt(tIxt[rowIdx]),
		.testCount(testCount), .failCount(failCount)
	);

	task automatic addRow(input logic [15:0] w, input archPkg::regId_t n,
			input archPkg::regId_t m, input archPkg::regId_t o, input logic [32:0] i,
			input logic [7:0] c, input logic [7:0] x);
		tWord[rowFill] = w;
		tN[rowFill] = n;
		tM[rowFill] = m;
		tO[rowFill] = o;
		tImm[rowFill] = i;
		tCmd[rowFill] = c;
		tIxt[rowFill] = x;
		rowFill++;
	endtask

	task automatic fillTable();
		addRow(16'h0000, archPkg::grZzr, archPkg::grZzr, archPkg::grZzr, '0,
			{archPkg::ccAlways, archPkg::ucmdNop}, {archPkg::ccAlways, 6'h00});
		// stores swap N and M
		addRow(16'h0123, 6'h03, 6'h02, archPkg::grZzr, '0, {archPkg::ccAlways,
			archPkg::ucmdMovRm}, {archPkg::ccAlways, 2'b01, 1'b0, decodePkg::btySw});
		addRow(16'h0C14, 6'h04, archPkg::grGbr, archPkg::grDlr, '0, {archPkg::ccAlways,
			archPkg::ucmdMovMr}, {archPkg::ccAlways, 2'b00, 1'b1, decodePkg::btySb});
		addRow(16'h0C34, 6'h04, 6'h03, archPkg::grDlr, '0, {archPkg::ccAlways,
			archPkg::ucmdMovMr}, {archPkg::ccAlways, 2'b00, 1'b1, decodePkg::btySb});
		// quad load off an R0 base, size field drops to byte
		addRow(16'h0F04, 6'h04, archPkg::grPc, archPkg::grDlr, '0, {archPkg::ccAlways,
			archPkg::ucmdMovMr}, {archPkg::ccAlways, 2'b11, 1'b1, decodePkg::btySb});
		addRow(16'h1023, 6'h02, 6'h02, 6'h03, '0,
			{archPkg::ccAlways, archPkg::ucmdAlu3}, {archPkg::ccAlways, archPkg::ucixAdd});
		addRow(16'h1B23, 6'h12, 6'h13, archPkg::grDlr, '0,
			{archPkg::ccAlways, archPkg::ucmdConvRr}, {archPkg::ccAlways, archPkg::ucixConvMov});
		addRow(16'h18F0, archPkg::grSp, archPkg::grDlr, archPkg::grDlr, '0,
			{archPkg::ccAlways, archPkg::ucmdConvRr}, {archPkg::ccAlways, archPkg::ucixConvMov});
		addRow(16'h2480, archPkg::grDlr, archPkg::grImm, archPkg::grZzr, 33'h080,
			{archPkg::ccAlways, archPkg::ucmdMovIr}, {archPkg::ccAlways, archPkg::ucixLdiX});
		addRow(16'h25F0, archPkg::grDlr, archPkg::grImm, archPkg::grZzr, {{25{1'b1}}, 8'hF0},
			{archPkg::ccAlways, archPkg::ucmdMovIr}, {archPkg::ccAlways, archPkg::ucixLdiX});
		addRow(16'hA123, archPkg::grDlr, archPkg::grImm, archPkg::grZzr, 33'h123,
			{archPkg::ccAlways, archPkg::ucmdMovIr}, {archPkg::ccAlways, archPkg::ucixLdiX});
		addRow(16'hB123, archPkg::grDlr, archPkg::grImm, archPkg::grZzr, {{21{1'b1}}, 12'h123},
			{archPkg::ccAlways, archPkg::ucmdMovIr}, {archPkg::ccAlways, archPkg::ucixLdiX});
		// R1 in the O field lands on DHR
		addRow(16'hC1FF, archPkg::grDhr, archPkg::grImm, archPkg::grDhr, {33{1'b1}},
			{archPkg::ccAlways, archPkg::ucmdAlu3}, {archPkg::ccAlways, archPkg::ucixAdd});
		addRow(16'h22FE, archPkg::grDlr, archPkg::grPc, archPkg::grImm, {{25{1'b1}}, 8'hFE},
			{archPkg::ccIfTrue, archPkg::ucmdBra}, {archPkg::ccIfTrue, 2'b01, 1'b1, decodePkg::btySw});
		addRow(16'h3010, archPkg::grZzr, archPkg::grLr, archPkg::grZzr, '0,
			{archPkg::ccAlways, archPkg::ucmdJmp}, {archPkg::ccAlways, 6'h00});
		addRow(16'h3050, archPkg::grZzr, archPkg::grZzr, archPkg::grZzr, '0,
			{archPkg::ccAlways, archPkg::ucmdOpIxt}, {archPkg::ccAlways, archPkg::ucixSett});
		addRow(16'h30B0, archPkg::grZzr, archPkg::grZzr, archPkg::grZzr, 33'h0FFFF,
			{archPkg::ccAlways, archPkg::ucmdMovIr}, {archPkg::ccAlways, archPkg::ucixLdiSh16});
		addRow(16'h9000, archPkg::grZzr, archPkg::grZzr, archPkg::grZzr, '0,
			{archPkg::ccAlways, archPkg::ucmdInvOp}, 8'h00);
		addRow(16'hE000, archPkg::grZzr, archPkg::grZzr, archPkg::grZzr, '0,
			{archPkg::ccAlways, archPkg::ucmdInvOp}, 8'h00);
	endtask

	initial begin
		int gap;
		void'($urandom(32'ha072bcd1));
		fillTable();
		repeat (8) @(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		for (int r = 0; r < numRows; r++) begin
			gap = $urandom % 4;
			repeat (gap) @(negedge clock);
			@(negedge clock);
			rowIdx = r;
			instrWord = tWord[r];
			instrReq = 1'b1;
			while (!instrAck) @(negedge clock);
			// word is free once acked, a different decode must not leak through
			instrWord = tWord[(r + numRows / 2) % numRows];
			// keep req up for a while, outputs must hold
			repeat (2) @(negedge clock);
			instrReq = 1'b0;
			while (instrAck) @(negedge clock);
		end
		@(posedge clock);
		$display("%0d tests run, %0d passed, %0d failed",
			testCount, testCount - failCount, failCount);
		if (testCount != numRows + 1)
			$display("checker finished %0d of %0d tests", testCount, numRows + 1);
		if (failCount == 0 && testCount == numRows + 1) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		repeat (numRows * 10 + 20) @(posedge clock);
		$display("watchdog: the run did not finish within %0d cycles", numRows * 10 + 20);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
common/archPkg.sv
common/decodePkg.sv
hw/decoder/regFieldExpand.sv
hw/decoder/opcodeClassify.sv
hw/decoder/operandForm.sv
hw/instrDecoder.sv
dv/decoderChecker.sv
dv/decoderTb.sv

// File: run.sh
#!/bin/sh
# build the decoder testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module decoderTb \
	-f src.f -o decoderSim &&
./obj_dir/decoderSim | tee sim.log &&
grep -q "^All tests passed$" sim.log &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
